// ==== dla_defs.svh ====
`ifndef DLA_DEFS_SVH
`define DLA_DEFS_SVH

// bus and buffer word widths
`define DLA_FEAT_W      128
`define DLA_WGT_W       64
`define DLA_INSTR_W     64

// address widths and depths
`define DLA_EXT_AW      16
`define DLA_BUF_AW      8
`define DLA_BUF_DEPTH   256
`define DLA_FIFO_DEPTH  8

// instruction word fields
`define DLA_OP_MSB      63
`define DLA_OP_LSB      60
`define DLA_SRC_MSB     31
`define DLA_SRC_LSB     16
`define DLA_DST_MSB     15
`define DLA_DST_LSB     8
`define DLA_CNT_MSB     7
`define DLA_CNT_LSB     0

`endif

// ==== dla_pkg.sv ====
`include "dla_defs.svh"
`default_nettype none

package dla_pkg;

    typedef logic [`DLA_INSTR_W-1:0]             instr_t;
    typedef logic [`DLA_EXT_AW-1:0]              ext_addr_t;   // instr, feature and weight buses
    typedef logic [`DLA_BUF_AW-1:0]              buf_addr_t;   // on-chip buffer index
    typedef logic [`DLA_CNT_MSB-`DLA_CNT_LSB:0]  burst_cnt_t;  // 0 moves nothing
    typedef logic [`DLA_FEAT_W-1:0]              feat_word_t;
    typedef logic [`DLA_WGT_W-1:0]               wgt_word_t;

    // opcode field, codes not listed are treated as nop
    typedef enum logic [3:0] {
        OP_NOP        = 4'h0,
        OP_FETCH_FEAT = 4'h1,
        OP_FETCH_WGT  = 4'h2,
        OP_FETCH_BIAS = 4'h3,
        OP_FETCH_SCAL = 4'h4,
        OP_HALT       = 4'hf
    } opcode_e;

    // target buffer, also the host read select
    typedef enum logic [1:0] {
        BUF_FEAT = 2'd0,
        BUF_WGT  = 2'd1,
        BUF_BIAS = 2'd2,
        BUF_SCAL = 2'd3
    } buf_sel_e;

    typedef enum logic [2:0] {
        IDLE,
        POP,
        WAIT_BURST,
        ACK,
        DROP
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== instr_fetch.sv ====
`include "dla_defs.svh"
`default_nettype none

module instr_fetch (
    input  wire logic               clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_start,        // run start pulse from the fsm
    input  wire dla_pkg::ext_addr_t i_start_addr,
    input  wire logic               i_fifo_afull,
    output logic                    o_instr_rd_en,
    output dla_pkg::ext_addr_t      o_instr_addr,
    input  wire dla_pkg::instr_t    i_instr_data,   // one cycle after rd_en
    output logic                    o_fifo_wr_en,
    output dla_pkg::instr_t         o_fifo_wr_data
);
    import dla_pkg::*;

    logic      active;      // start seen, halt not yet written
    logic      rd_pend;     // read issued last cycle
    logic      is_halt;
    ext_addr_t rd_addr;

    // afull leaves one free slot for the word in flight
    assign o_instr_rd_en  = active & ~i_fifo_afull;
    assign o_instr_addr   = rd_addr;
    assign o_fifo_wr_en   = rd_pend & active;   // returns after halt are dropped
    assign o_fifo_wr_data = i_instr_data;

    assign is_halt = (opcode_e'(i_instr_data[`DLA_OP_MSB:`DLA_OP_LSB]) == OP_HALT);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active  <= 1'b0;
            rd_pend <= 1'b0;
            rd_addr <= '0;
        end else begin
            rd_pend <= o_instr_rd_en;
            if (i_start) begin
                active  <= 1'b1;
                rd_addr <= i_start_addr;
            end else begin
                if (o_instr_rd_en)
                    rd_addr <= rd_addr + 1'b1;   // sequential program
                if (o_fifo_wr_en && is_halt)
                    active <= 1'b0;              // stop at the first halt
            end
        end
    end

endmodule

`default_nettype wire

// ==== instr_fifo.sv ====
`include "dla_defs.svh"
`default_nettype none

module instr_fifo (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_clear,    // run start, drop everything
    input  wire logic             i_wr_en,
    input  wire dla_pkg::instr_t  i_wr_data,
    input  wire logic             i_rd_en,
    output dla_pkg::instr_t       o_rd_data,  // head, valid with the pop
    output logic                  o_empty,
    output logic                  o_afull
);
    import dla_pkg::*;

    localparam int DEPTH = `DLA_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    instr_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    assign o_rd_data = mem[rd_ptr];
    assign o_empty   = (count == '0);
    assign o_afull   = (count >= DEPTH - 1);

    always_ff @(posedge clk) begin
        if (i_wr_en)
            mem[wr_ptr] <= i_wr_data;
    end

    ////////////////////////////////////////
    // pointers and fill count
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr_en)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (i_rd_en)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({i_wr_en, i_rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // both or neither
            endcase
        end
    end

    // fetcher honours afull with one read in flight
    a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wr_en |-> (count < DEPTH))
        else $error("instruction fifo written while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rd_en |-> !o_empty)
        else $error("instruction fifo popped while empty");

endmodule

`default_nettype wire

// ==== dla_ctrl_fsm.sv ====
`include "dla_defs.svh"
`default_nettype none

module dla_ctrl_fsm (
    input  wire logic                clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_run_req,
    input  wire dla_pkg::ext_addr_t  i_prog_addr,
    output logic                     o_run_ack,
    output logic                     o_fetch_start,
    output dla_pkg::ext_addr_t       o_fetch_addr,
    output logic                     o_fifo_clear,
    input  wire logic                i_fifo_empty,
    output logic                     o_fifo_pop,
    input  wire dla_pkg::instr_t     i_instr,      // fifo head
    output logic                     o_burst_start,
    output dla_pkg::buf_sel_e        o_burst_sel,
    output dla_pkg::ext_addr_t       o_burst_src,
    output dla_pkg::buf_addr_t       o_burst_dst,
    output dla_pkg::burst_cnt_t      o_burst_cnt,
    input  wire logic                i_burst_done
);
    import dla_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    opcode_e     op;
    burst_cnt_t  cnt;
    buf_sel_e    sel_dec;
    logic        go_burst;     // fetch with a nonzero count
    logic        run_start;

    assign op  = opcode_e'(i_instr[`DLA_OP_MSB:`DLA_OP_LSB]);
    assign cnt = i_instr[`DLA_CNT_MSB:`DLA_CNT_LSB];

    // run start clears the fifo and kicks the fetcher in one cycle
    assign run_start     = (state == IDLE) & i_run_req;
    assign o_fetch_start = run_start;
    assign o_fifo_clear  = run_start;
    assign o_fetch_addr  = i_prog_addr;     // held stable by the host during req
    assign o_fifo_pop    = (state == POP) & ~i_fifo_empty;
    assign o_run_ack     = (state == ACK);

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    always_comb begin
        go_burst = 1'b0;
        sel_dec  = BUF_FEAT;
        case (op)
            OP_FETCH_FEAT: begin go_burst = (cnt != '0); sel_dec = BUF_FEAT; end
            OP_FETCH_WGT:  begin go_burst = (cnt != '0); sel_dec = BUF_WGT;  end
            OP_FETCH_BIAS: begin go_burst = (cnt != '0); sel_dec = BUF_BIAS; end
            OP_FETCH_SCAL: begin go_burst = (cnt != '0); sel_dec = BUF_SCAL; end
            default:       go_burst = 1'b0;   // nop, halt, unknown
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (i_run_req) state_nxt = POP;
            POP: begin
                if (o_fifo_pop) begin
                    if (op == OP_HALT)
                        state_nxt = ACK;           // no burst can be active here
                    else if (go_burst)
                        state_nxt = WAIT_BURST;
                    else
                        state_nxt = DROP;          // nop or count 0
                end
            end
            WAIT_BURST: if (i_burst_done) state_nxt = POP;
            DROP:       state_nxt = POP;
            ACK:        if (!i_run_req) state_nxt = IDLE;   // ack drops next cycle
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= IDLE;
            o_burst_start <= 1'b0;
        end else begin
            state         <= state_nxt;
            o_burst_start <= o_fifo_pop & go_burst;  // one cycle after the pop
        end
    end

    // burst fields, captured with the pop
    always_ff @(posedge clk) begin
        if (o_fifo_pop) begin
            o_burst_sel <= sel_dec;
            o_burst_src <= i_instr[`DLA_SRC_MSB:`DLA_SRC_LSB];
            o_burst_dst <= i_instr[`DLA_DST_MSB:`DLA_DST_LSB];
            o_burst_cnt <= cnt;
        end
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(o_run_ack) |-> i_run_req)
        else $error("run ack raised with no run request");

endmodule

`default_nettype wire

// ==== burst_counter.sv ====
`include "dla_defs.svh"
`default_nettype none

module burst_counter (
    input  wire logic                clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_start,
    input  wire dla_pkg::buf_sel_e   i_sel,
    input  wire dla_pkg::ext_addr_t  i_src,
    input  wire dla_pkg::buf_addr_t  i_dst,
    input  wire dla_pkg::burst_cnt_t i_cnt,
    output logic                     o_feat_rd_en,
    output dla_pkg::ext_addr_t       o_feat_addr,
    output logic                     o_wgt_rd_en,
    output dla_pkg::ext_addr_t       o_wgt_addr,
    output logic                     o_wr_en_feat,
    output logic                     o_wr_en_wgt,
    output logic                     o_wr_en_bias,
    output logic                     o_wr_en_scal,
    output dla_pkg::buf_addr_t       o_wr_addr,
    output logic                     o_done      // count + 1 cycles after start
);
    import dla_pkg::*;

    logic       busy;       // read side active
    logic       last;
    logic       wr_v;       // write stage, read side one cycle late
    burst_cnt_t idx;
    burst_cnt_t cnt_q;
    buf_sel_e   sel_q;
    buf_sel_e   wr_sel;
    ext_addr_t  src_q;
    ext_addr_t  rd_addr;
    buf_addr_t  dst_q;

    assign last    = (idx == cnt_q - 1'b1);
    assign rd_addr = src_q + ext_addr_t'(idx);

    // feature fetches use the data bus, the rest the weight bus
    assign o_feat_rd_en = busy & (sel_q == BUF_FEAT);
    assign o_wgt_rd_en  = busy & (sel_q != BUF_FEAT);
    assign o_feat_addr  = rd_addr;
    assign o_wgt_addr   = rd_addr;

    assign o_wr_en_feat = wr_v & (wr_sel == BUF_FEAT);
    assign o_wr_en_wgt  = wr_v & (wr_sel == BUF_WGT);
    assign o_wr_en_bias = wr_v & (wr_sel == BUF_BIAS);
    assign o_wr_en_scal = wr_v & (wr_sel == BUF_SCAL);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy   <= 1'b0;
            idx    <= '0;
            wr_v   <= 1'b0;
            o_done <= 1'b0;
        end else begin
            wr_v   <= busy;
            o_done <= (busy & last) | (i_start & (i_cnt == '0));  // lands on the last write
            if (i_start) begin
                busy <= (i_cnt != '0);
                idx  <= '0;
            end else if (busy) begin
                idx <= idx + 1'b1;
                if (last)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            sel_q <= i_sel;
            src_q <= i_src;
            dst_q <= i_dst;
            cnt_q <= i_cnt;
        end
        wr_sel    <= sel_q;
        o_wr_addr <= dst_q + buf_addr_t'(idx);  // wraps mod 256
    end

    // fsm waits for done before the next pop
    a_start_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_start |-> (!busy && !wr_v))
        else $error("burst started while the previous one is in progress");

endmodule

`default_nettype wire

// ==== data_buffer.sv ====
`include "dla_defs.svh"
`default_nettype none

module data_buffer #(
    parameter int WIDTH = `DLA_WGT_W,
    parameter int DEPTH = `DLA_BUF_DEPTH
) (
    input  wire logic               clk,
    input  wire logic               i_wr_en,
    input  wire dla_pkg::buf_addr_t i_wr_addr,
    input  wire logic [WIDTH-1:0]   i_wr_data,   // straight from the bus
    input  wire dla_pkg::buf_addr_t i_rd_addr,
    output logic [WIDTH-1:0]        o_rd_data    // one cycle after the address
);
    import dla_pkg::*;

    logic [WIDTH-1:0] mem [DEPTH];

    // destination wrap relies on depth matching the address range
    if (DEPTH != (1 << $bits(buf_addr_t))) begin : g_depth_chk
        $error("data_buffer depth does not match the buffer address width");
    end

    ////////////////////////////////////////
    // one write port, one read port
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_data;
        o_rd_data <= mem[i_rd_addr];     // read during write gives old data
    end

endmodule

`default_nettype wire

// ==== dla_top.sv ====
`include "dla_defs.svh"
`default_nettype none

module dla_top (
    input  wire logic                clk,
    input  wire logic                i_rst_n,
    // run handshake
    input  wire logic                i_run_req,
    input  wire dla_pkg::ext_addr_t  i_prog_addr,
    output logic                     o_run_ack,
    // instruction memory
    output logic                     o_instr_rd_en,
    output dla_pkg::ext_addr_t       o_instr_addr,
    input  wire dla_pkg::instr_t     i_instr_data,
    // feature bus, 128 bit
    output logic                     o_feat_rd_en,
    output dla_pkg::ext_addr_t       o_feat_addr,
    input  wire dla_pkg::feat_word_t i_feat_data,
    // weight bus, 64 bit
    output logic                     o_wgt_rd_en,
    output dla_pkg::ext_addr_t       o_wgt_addr,
    input  wire dla_pkg::wgt_word_t  i_wgt_data,
    // host read port, valid only between runs
    input  wire dla_pkg::buf_sel_e   i_host_rd_sel,
    input  wire dla_pkg::buf_addr_t  i_host_rd_addr,
    output dla_pkg::feat_word_t      o_host_rd_data
);
    import dla_pkg::*;

    logic       fetch_start;
    ext_addr_t  fetch_addr;
    logic       fifo_clear;
    logic       fifo_wr_en;
    instr_t     fifo_wr_data;
    logic       fifo_pop;
    instr_t     fifo_head;
    logic       fifo_empty;
    logic       fifo_afull;
    logic       burst_start;
    buf_sel_e   burst_sel;
    ext_addr_t  burst_src;
    buf_addr_t  burst_dst;
    burst_cnt_t burst_cnt;
    logic       burst_done;
    logic       wr_en_feat;
    logic       wr_en_wgt;
    logic       wr_en_bias;
    logic       wr_en_scal;
    buf_addr_t  buf_wr_addr;
    feat_word_t feat_rd;
    wgt_word_t  wgt_rd;
    wgt_word_t  bias_rd;
    wgt_word_t  scal_rd;
    buf_sel_e   host_sel_q;

    ////////////////////////////////////////
    // instruction path
    ////////////////////////////////////////
    instr_fetch u_fetch (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_start        (fetch_start),
        .i_start_addr   (fetch_addr),
        .i_fifo_afull   (fifo_afull),
        .o_instr_rd_en  (o_instr_rd_en),
        .o_instr_addr   (o_instr_addr),
        .i_instr_data   (i_instr_data),
        .o_fifo_wr_en   (fifo_wr_en),
        .o_fifo_wr_data (fifo_wr_data)
    );

    instr_fifo u_fifo (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_clear   (fifo_clear),
        .i_wr_en   (fifo_wr_en),
        .i_wr_data (fifo_wr_data),
        .i_rd_en   (fifo_pop),
        .o_rd_data (fifo_head),
        .o_empty   (fifo_empty),
        .o_afull   (fifo_afull)
    );

    dla_ctrl_fsm u_ctrl (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_run_req     (i_run_req),
        .i_prog_addr   (i_prog_addr),
        .o_run_ack     (o_run_ack),
        .o_fetch_start (fetch_start),
        .o_fetch_addr  (fetch_addr),
        .o_fifo_clear  (fifo_clear),
        .i_fifo_empty  (fifo_empty),
        .o_fifo_pop    (fifo_pop),
        .i_instr       (fifo_head),
        .o_burst_start (burst_start),
        .o_burst_sel   (burst_sel),
        .o_burst_src   (burst_src),
        .o_burst_dst   (burst_dst),
        .o_burst_cnt   (burst_cnt),
        .i_burst_done  (burst_done)
    );

    ////////////////////////////////////////
    // bursts into the buffers
    ////////////////////////////////////////
    burst_counter u_burst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_start      (burst_start),
        .i_sel        (burst_sel),
        .i_src        (burst_src),
        .i_dst        (burst_dst),
        .i_cnt        (burst_cnt),
        .o_feat_rd_en (o_feat_rd_en),
        .o_feat_addr  (o_feat_addr),
        .o_wgt_rd_en  (o_wgt_rd_en),
        .o_wgt_addr   (o_wgt_addr),
        .o_wr_en_feat (wr_en_feat),
        .o_wr_en_wgt  (wr_en_wgt),
        .o_wr_en_bias (wr_en_bias),
        .o_wr_en_scal (wr_en_scal),
        .o_wr_addr    (buf_wr_addr),
        .o_done       (burst_done)
    );

    data_buffer #(.WIDTH(`DLA_FEAT_W), .DEPTH(`DLA_BUF_DEPTH)) feat_buf (
        .clk(clk), .i_wr_en(wr_en_feat), .i_wr_addr(buf_wr_addr),
        .i_wr_data(i_feat_data), .i_rd_addr(i_host_rd_addr), .o_rd_data(feat_rd)
    );

    data_buffer #(.WIDTH(`DLA_WGT_W), .DEPTH(`DLA_BUF_DEPTH)) wgt_buf (
        .clk(clk), .i_wr_en(wr_en_wgt), .i_wr_addr(buf_wr_addr),
        .i_wr_data(i_wgt_data), .i_rd_addr(i_host_rd_addr), .o_rd_data(wgt_rd)
    );

    data_buffer #(.WIDTH(`DLA_WGT_W), .DEPTH(`DLA_BUF_DEPTH)) bias_buf (
        .clk(clk), .i_wr_en(wr_en_bias), .i_wr_addr(buf_wr_addr),
        .i_wr_data(i_wgt_data), .i_rd_addr(i_host_rd_addr), .o_rd_data(bias_rd)
    );

    data_buffer #(.WIDTH(`DLA_WGT_W), .DEPTH(`DLA_BUF_DEPTH)) scal_buf (
        .clk(clk), .i_wr_en(wr_en_scal), .i_wr_addr(buf_wr_addr),
        .i_wr_data(i_wgt_data), .i_rd_addr(i_host_rd_addr), .o_rd_data(scal_rd)
    );

    // select follows the registered buffer read by one cycle
    always_ff @(posedge clk) begin
        host_sel_q <= i_host_rd_sel;
    end

    always_comb begin
        case (host_sel_q)
            BUF_FEAT: o_host_rd_data = feat_rd;
            BUF_WGT:  o_host_rd_data = feat_word_t'(wgt_rd);    // zero extended
            BUF_BIAS: o_host_rd_data = feat_word_t'(bias_rd);
            default:  o_host_rd_data = feat_word_t'(scal_rd);
        endcase
    end

endmodule

`default_nettype wire

// ==== tb_dla.sv ====
`include "dla_defs.svh"
`default_nettype none

module tb_dla;
    import dla_pkg::*;

    localparam int          CLK_PERIOD = 8;
    localparam int          MEM_WORDS  = 4096;     // beyond this the models return X
    localparam int          RAND_LEN   = 16;       // twice the fifo depth
    localparam logic [31:0] SEED       = 32'h7848_27ef;
    localparam ext_addr_t   P_FEAT     = 16'h0010;
    localparam ext_addr_t   P_WBS      = 16'h0020;
    localparam ext_addr_t   P_RAND     = 16'h0100;
    localparam ext_addr_t   P_FIRST    = 16'h0200;
    localparam ext_addr_t   P_SECOND   = 16'h0280;

    logic       clk;
    logic       i_rst_n;
    logic       i_run_req;
    ext_addr_t  i_prog_addr;
    logic       o_run_ack;
    logic       o_instr_rd_en;
    ext_addr_t  o_instr_addr;
    instr_t     i_instr_data;
    logic       o_feat_rd_en;
    ext_addr_t  o_feat_addr;
    feat_word_t i_feat_data;
    logic       o_wgt_rd_en;
    ext_addr_t  o_wgt_addr;
    wgt_word_t  i_wgt_data;
    buf_sel_e   i_host_rd_sel;
    buf_addr_t  i_host_rd_addr;
    feat_word_t o_host_rd_data;

    instr_t     instr_mem [MEM_WORDS];
    feat_word_t feat_mem  [MEM_WORDS];
    wgt_word_t  wgt_mem   [MEM_WORDS];
    feat_word_t shadow_feat [256];          // expected buffer contents
    wgt_word_t  shadow_wgt  [256];
    wgt_word_t  shadow_bias [256];
    wgt_word_t  shadow_scal [256];
    bit         touched [4][256];           // addresses any run has written

    logic [31:0] rng;
    int          budget = 0;                // watchdog arms once nonzero
    int          checks = 0;
    int          errors = 0;
    int          tests  = 0;

    dla_top DUT (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_run_req(i_run_req), .i_prog_addr(i_prog_addr), .o_run_ack(o_run_ack),
        .o_instr_rd_en(o_instr_rd_en), .o_instr_addr(o_instr_addr),
        .i_instr_data(i_instr_data),
        .o_feat_rd_en(o_feat_rd_en), .o_feat_addr(o_feat_addr), .i_feat_data(i_feat_data),
        .o_wgt_rd_en(o_wgt_rd_en), .o_wgt_addr(o_wgt_addr), .i_wgt_data(i_wgt_data),
        .i_host_rd_sel(i_host_rd_sel), .i_host_rd_addr(i_host_rd_addr),
        .o_host_rd_data(o_host_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // external memories, data one cycle after the read enable
    always @(posedge clk) begin
        if (o_instr_rd_en)
            i_instr_data <= instr_mem[o_instr_addr];
        if (o_feat_rd_en)
            i_feat_data <= feat_mem[o_feat_addr];
        if (o_wgt_rd_en)
            i_wgt_data <= wgt_mem[o_wgt_addr];
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic instr_t make_instr(input logic [3:0] op, input ext_addr_t src,
                                          input buf_addr_t dst, input burst_cnt_t cnt);
        instr_t w;
        w = '0;
        w[`DLA_OP_MSB:`DLA_OP_LSB]   = op;
        w[`DLA_SRC_MSB:`DLA_SRC_LSB] = src;
        w[`DLA_DST_MSB:`DLA_DST_LSB] = dst;
        w[`DLA_CNT_MSB:`DLA_CNT_LSB] = cnt;
        return w;
    endfunction

    // mix of fetches, nops and an unknown code, a few slots forced
    task automatic build_random_program(input ext_addr_t base);
        logic [31:0] r;
        logic [3:0]  op;
        int          i;
        for (i = 0; i < RAND_LEN; i++) begin
            r = next_rand();
            case (r[2:0])
                3'd0:    op = OP_NOP;
                3'd1:    op = OP_FETCH_FEAT;
                3'd2:    op = OP_FETCH_WGT;
                3'd3:    op = OP_FETCH_BIAS;
                3'd4:    op = OP_FETCH_SCAL;
                3'd5:    op = 4'h9;            // unknown code
                3'd6:    op = OP_FETCH_FEAT;
                default: op = OP_FETCH_SCAL;
            endcase
            instr_mem[base + i] = make_instr(op, ext_addr_t'(r[30:20]), r[15:8],
                                             burst_cnt_t'(r[19:16]) + 8'd1);
        end
        instr_mem[base + 2]  = make_instr(OP_NOP, 16'h0, 8'h0, 8'd5);
        instr_mem[base + 5]  = make_instr(OP_FETCH_FEAT, 16'h0300, 8'h40, 8'd0);   // count 0
        instr_mem[base + 9]  = make_instr(OP_FETCH_WGT, 16'h0320, 8'hf8, 8'd12);   // wraps
        instr_mem[base + 12] = make_instr(OP_FETCH_FEAT, 16'h0340, 8'hfc, 8'd8);
        instr_mem[base + RAND_LEN] = make_instr(OP_HALT, 16'h0, 8'h0, 8'd0);
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    // copies count words src+i to dst+i mod 256 until the first halt
    function automatic void apply_program(input ext_addr_t start);
        ext_addr_t pc;
        instr_t    w;
        ext_addr_t src;
        buf_addr_t dst;
        int        n;
        int        kind;
        int        i;
        pc = start;
        w  = instr_mem[pc];
        while (w[`DLA_OP_MSB:`DLA_OP_LSB] != OP_HALT) begin
            src = w[`DLA_SRC_MSB:`DLA_SRC_LSB];
            dst = w[`DLA_DST_MSB:`DLA_DST_LSB];
            n   = w[`DLA_CNT_MSB:`DLA_CNT_LSB];
            case (w[`DLA_OP_MSB:`DLA_OP_LSB])
                OP_FETCH_FEAT: kind = BUF_FEAT;
                OP_FETCH_WGT:  kind = BUF_WGT;
                OP_FETCH_BIAS: kind = BUF_BIAS;
                OP_FETCH_SCAL: kind = BUF_SCAL;
                default:       kind = -1;      // nop and unknown codes
            endcase
            for (i = 0; i < n && kind >= 0; i++) begin
                case (kind)
                    0:       shadow_feat[dst] = feat_mem[src];
                    1:       shadow_wgt[dst]  = wgt_mem[src];
                    2:       shadow_bias[dst] = wgt_mem[src];
                    default: shadow_scal[dst] = wgt_mem[src];
                endcase
                touched[kind][dst] = 1'b1;
                src = src + 1'b1;
                dst = dst + 1'b1;              // 8 bit, wraps by itself
            end
            pc = pc + 1'b1;
            w  = instr_mem[pc];
        end
    endfunction

    function automatic int program_cost(input ext_addr_t start);
        ext_addr_t pc;
        int        cycles;
        pc     = start;
        cycles = 200;                          // the halt word
        while (instr_mem[pc][`DLA_OP_MSB:`DLA_OP_LSB] != OP_HALT) begin
            cycles = cycles + 200 + 50 * int'(instr_mem[pc][`DLA_CNT_MSB:`DLA_CNT_LSB]);
            pc     = pc + 1'b1;
        end
        return cycles;
    endfunction

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    task automatic check_feat(input string name, input feat_word_t got, input feat_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_wgt(input string name, input wgt_word_t got, input wgt_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // host port, data one cycle after the address
    task automatic host_read(input buf_sel_e sel, input buf_addr_t a, output feat_word_t d);
        @(posedge clk);
        i_host_rd_sel  <= sel;
        i_host_rd_addr <= a;
        @(posedge clk);
        @(negedge clk);
        d = o_host_rd_data;
    endtask

    task automatic check_narrow(input buf_sel_e sel, input string tag, input int a,
                                input wgt_word_t exp);
        feat_word_t d;
        host_read(sel, buf_addr_t'(a), d);
        check_wgt($sformatf("%s[%02h]", tag, a), d[63:0], exp);
        check_wgt($sformatf("%s[%02h] upper half", tag, a), d[127:64], '0);  // zero extended
    endtask

    task automatic compare_buffers();
        feat_word_t d;
        int         a;
        for (a = 0; a < 256; a++) begin
            if (touched[BUF_FEAT][a]) begin
                host_read(BUF_FEAT, buf_addr_t'(a), d);
                check_feat($sformatf("feat_buf[%02h]", a), d, shadow_feat[a]);
            end
            if (touched[BUF_WGT][a])
                check_narrow(BUF_WGT, "wgt_buf", a, shadow_wgt[a]);
            if (touched[BUF_BIAS][a])
                check_narrow(BUF_BIAS, "bias_buf", a, shadow_bias[a]);
            if (touched[BUF_SCAL][a])
                check_narrow(BUF_SCAL, "scal_buf", a, shadow_scal[a]);
        end
    endtask

    // four phase req/ack, then reference update and readback
    task automatic run_program(input ext_addr_t addr);
        @(posedge clk);
        i_prog_addr <= addr;
        i_run_req   <= 1'b1;
        @(negedge clk);
        check_ack("o_run_ack right after req", o_run_ack, 1'b0);
        while (o_run_ack !== 1'b1)
            @(negedge clk);                    // watchdog catches a hang
        @(posedge clk);
        i_run_req <= 1'b0;
        @(negedge clk);
        check_ack("o_run_ack while req falls", o_run_ack, 1'b1);
        @(negedge clk);
        check_ack("o_run_ack after req low", o_run_ack, 1'b0);
        apply_program(addr);
        compare_buffers();
    endtask

    task automatic report(input int num, input string what, input int err_before);
        tests++;
        if (errors == err_before)
            $display("test %0d %s: ok", num, what);
        else
            $display("test %0d %s: %0d errors", num, what, errors - err_before);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int i;
        int err0;
        i_rst_n        = 1'b0;
        i_run_req      = 1'b0;
        i_prog_addr    = '0;
        i_instr_data   = '0;
        i_feat_data    = '0;
        i_wgt_data     = '0;
        i_host_rd_sel  = BUF_FEAT;
        i_host_rd_addr = '0;
        rng            = SEED;
        for (i = 0; i < MEM_WORDS; i++) begin
            instr_mem[i] = make_instr(OP_HALT, 16'h0, 8'h0, 8'h0) | instr_t'(i);  // halt filler
            feat_mem[i]  = {next_rand(), next_rand(), next_rand(), next_rand()};
            wgt_mem[i]   = {next_rand(), next_rand()};
        end
        instr_mem[P_FEAT]     = make_instr(OP_FETCH_FEAT, 16'h0040, 8'h00, 8'd10);
        instr_mem[P_FEAT + 1] = make_instr(OP_HALT, 16'h0, 8'h0, 8'd0);
        // wide fills, then narrow overwrites inside them
        instr_mem[P_WBS]      = make_instr(OP_FETCH_WGT, 16'h0100, 8'h20, 8'd16);
        instr_mem[P_WBS + 1]  = make_instr(OP_FETCH_BIAS, 16'h0200, 8'h20, 8'd16);
        instr_mem[P_WBS + 2]  = make_instr(OP_FETCH_SCAL, 16'h0300, 8'h20, 8'd16);
        instr_mem[P_WBS + 3]  = make_instr(OP_FETCH_WGT, 16'h0400, 8'h24, 8'd4);
        instr_mem[P_WBS + 4]  = make_instr(OP_FETCH_BIAS, 16'h0500, 8'h28, 8'd3);
        instr_mem[P_WBS + 5]  = make_instr(OP_FETCH_SCAL, 16'h0600, 8'h2c, 8'd2);
        instr_mem[P_WBS + 6]  = make_instr(OP_HALT, 16'h0, 8'h0, 8'd0);
        build_random_program(P_RAND);
        instr_mem[P_FIRST]     = make_instr(OP_FETCH_FEAT, 16'h0700, 8'h80, 8'd8);
        instr_mem[P_FIRST + 1] = make_instr(OP_HALT, 16'h0, 8'h0, 8'd0);
        // stale words past the halt, must never run
        instr_mem[P_FIRST + 2] = make_instr(OP_FETCH_FEAT, 16'h0900, 8'h80, 8'd8);
        instr_mem[P_FIRST + 3] = make_instr(OP_FETCH_WGT, 16'h0900, 8'h20, 8'd8);
        instr_mem[P_FIRST + 4] = make_instr(OP_FETCH_SCAL, 16'h0900, 8'h20, 8'd8);
        instr_mem[P_SECOND]     = make_instr(OP_FETCH_WGT, 16'h0a00, 8'h90, 8'd5);
        instr_mem[P_SECOND + 1] = make_instr(OP_FETCH_FEAT, 16'h0b00, 8'h84, 8'd2);
        instr_mem[P_SECOND + 2] = make_instr(OP_HALT, 16'h0, 8'h0, 8'd0);
        budget = 100 + program_cost(P_FEAT) + program_cost(P_WBS) + program_cost(P_RAND)
               + program_cost(P_FIRST) + program_cost(P_SECOND);

        repeat (5) @(posedge clk);
        i_rst_n <= 1'b1;

        err0 = errors;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            check_ack("o_run_ack", o_run_ack, 1'b0);
            check_ack("o_instr_rd_en", o_instr_rd_en, 1'b0);
            check_ack("o_feat_rd_en", o_feat_rd_en, 1'b0);
            check_ack("o_wgt_rd_en", o_wgt_rd_en, 1'b0);
        end
        report(1, "idle outputs after reset", err0);

        err0 = errors;
        run_program(P_FEAT);
        report(2, "feature fetch and handshake", err0);

        err0 = errors;
        run_program(P_WBS);
        report(3, "weight, bias and scaler fetches", err0);

        err0 = errors;
        run_program(P_RAND);
        report(4, "random program deeper than the fifo", err0);

        err0 = errors;
        run_program(P_FIRST);
        run_program(P_SECOND);
        report(5, "back to back runs at new addresses", err0);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // limit scales with program and burst lengths
    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("timeout: the runs did not finish within %0d cycles", budget);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
dla_pkg.sv
instr_fetch.sv
instr_fifo.sv
dla_ctrl_fsm.sv
burst_counter.sv
data_buffer.sv
dla_top.sv
tb_dla.sv
